/* build.f */
logic/dmem_pkg.sv
logic/burst_arbiter.sv
logic/stride_agu.sv
logic/data_ram.sv
logic/store_channel.sv
logic/load_channel.sv
logic/dmem.sv
test/tb_clock_gen.sv
test/dmem_tb.sv

/* Bender.yml */
package:
  name: dmem

sources:
  - logic/dmem_pkg.sv
  - logic/burst_arbiter.sv
  - logic/stride_agu.sv
  - logic/data_ram.sv
  - logic/store_channel.sv
  - logic/load_channel.sv
  - logic/dmem.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/dmem_tb.sv

/* test/dmem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_tb;

	localparam int FILL_BURSTS = dmem_pkg::MEM_DEPTH / 16;
	localparam int ROUND_TRIPS = 12;
	localparam int PRESSURE_BURSTS = 8;
	localparam int SHARED_BURSTS = 8;
	localparam int TOTAL_BURSTS = 2 + FILL_BURSTS + 2 * ROUND_TRIPS + 2 + PRESSURE_BURSTS
		+ 2 * SHARED_BURSTS + FILL_BURSTS;
	localparam int STALL_CYCLES = 8;	// Allowance per beat
	localparam int CLOCK_NS = 40;
	localparam int WATCHDOG_NS = TOTAL_BURSTS * 16 * STALL_CYCLES * CLOCK_NS;

	wire clock;
	wire reset;

	logic [2:1] st_req;
	logic [2:1] st_valid;
	logic [2:1] ld_req;
	logic [2:1] ld_ready;
	dmem_pkg::address_t st_base [1:2];
	dmem_pkg::address_t st_stride [1:2];
	dmem_pkg::length_t st_length [1:2];
	dmem_pkg::data_t st_data [1:2];
	dmem_pkg::address_t ld_base [1:2];
	dmem_pkg::address_t ld_stride [1:2];
	dmem_pkg::length_t ld_length [1:2];
	wire [2:1] st_grant;
	wire [2:1] st_ready;
	wire [2:1] ld_grant;
	wire [2:1] ld_valid;
	wire [dmem_pkg::DATA_WIDTH-1:0] ld_data_1;
	wire [dmem_pkg::DATA_WIDTH-1:0] ld_data_2;

	dmem_pkg::data_t model [dmem_pkg::MEM_DEPTH];	// Expected memory contents
	integer seed;
	int mismatches;
	int failures;
	int st_order [$];	// Requesters in the order their grants rose
	int ld_order [$];
	logic [2:1] st_grant_q;
	logic [2:1] ld_grant_q;

	tb_clock_gen u_clock_gen (
		.clock(clock),
		.reset(reset)
	);

	dmem u_dut (
		.clock(clock),
		.reset(reset),
		.st_req_1(st_req[1]),
		.st_base_1(st_base[1]),
		.st_stride_1(st_stride[1]),
		.st_length_1(st_length[1]),
		.st_valid_1(st_valid[1]),
		.st_data_1(st_data[1]),
		.st_grant_1(st_grant[1]),
		.st_ready_1(st_ready[1]),
		.st_req_2(st_req[2]),
		.st_base_2(st_base[2]),
		.st_stride_2(st_stride[2]),
		.st_length_2(st_length[2]),
		.st_valid_2(st_valid[2]),
		.st_data_2(st_data[2]),
		.st_grant_2(st_grant[2]),
		.st_ready_2(st_ready[2]),
		.ld_req_1(ld_req[1]),
		.ld_base_1(ld_base[1]),
		.ld_stride_1(ld_stride[1]),
		.ld_length_1(ld_length[1]),
		.ld_ready_1(ld_ready[1]),
		.ld_grant_1(ld_grant[1]),
		.ld_valid_1(ld_valid[1]),
		.ld_data_1(ld_data_1),
		.ld_req_2(ld_req[2]),
		.ld_base_2(ld_base[2]),
		.ld_stride_2(ld_stride[2]),
		.ld_length_2(ld_length[2]),
		.ld_ready_2(ld_ready[2]),
		.ld_grant_2(ld_grant[2]),
		.ld_valid_2(ld_valid[2]),
		.ld_data_2(ld_data_2)
	);

	function automatic int unsigned rand_below(input int unsigned range);
		return $unsigned($random(seed)) % range;
	endfunction

	// Word address of beat k modulo the depth
	function automatic int beat_address(input dmem_pkg::address_t base,
			input dmem_pkg::address_t stride, input int beat);
		return (int'(base) + beat * int'(stride)) % dmem_pkg::MEM_DEPTH;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] want,
			input logic [31:0] got);
		mismatches++;
		$display("MISMATCH at %0d ns: %s expected %h, got %h", $time, name, want, got);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("ERROR at %0d ns: %s", $time, what);
	endtask

	task automatic check_idle();
		int n;
		for (n = 1; n <= 2; n++) begin
			if (st_grant[n] !== 1'b0) begin
				report_mismatch($sformatf("st_grant_%0d", n), 0, st_grant[n]);
			end
			if (st_ready[n] !== 1'b0) begin
				report_mismatch($sformatf("st_ready_%0d", n), 0, st_ready[n]);
			end
			if (ld_grant[n] !== 1'b0) begin
				report_mismatch($sformatf("ld_grant_%0d", n), 0, ld_grant[n]);
			end
			if (ld_valid[n] !== 1'b0) begin
				report_mismatch($sformatf("ld_valid_%0d", n), 0, ld_valid[n]);
			end
		end
	endtask

	task automatic check_order(input bit is_load, input int mark, input int want_first);
		int count;
		int got_first;
		int got_second;
		count = is_load ? ld_order.size() - mark : st_order.size() - mark;
		if (count != 2) begin
			report_failure($sformatf("arbitration gave %0d grants instead of 2", count));
		end else begin
			got_first = is_load ? ld_order[mark] : st_order[mark];
			got_second = is_load ? ld_order[mark + 1] : st_order[mark + 1];
			if (got_first != want_first) begin
				report_mismatch(is_load ? "first ld_grant" : "first st_grant", want_first,
					got_first);
			end
			if (got_second != 3 - want_first) begin
				report_mismatch(is_load ? "second ld_grant" : "second st_grant",
					3 - want_first, got_second);
			end
		end
	endtask

	task automatic store_burst(input int n, input dmem_pkg::address_t base,
			input dmem_pkg::address_t stride, input dmem_pkg::length_t length,
			input int gap_pct);
		dmem_pkg::data_t word;
		int beat;
		logic go;
		next_cycle();
		st_req[n] = 1'b1;
		st_base[n] = base;
		st_stride[n] = stride;
		st_length[n] = length;
		while (!st_grant[n]) next_cycle();
		st_req[n] = 1'b0;
		beat = 0;
		while (beat < length) begin
			if (!st_grant[n]) begin
				report_failure($sformatf("st_grant_%0d fell after %0d beats", n, beat));
				break;
			end
			go = rand_below(100) >= gap_pct;
			word = $random(seed);
			st_valid[n] = go;
			st_data[n] = word;
			next_cycle();
			if (go) begin
				model[beat_address(base, stride, beat)] = word;	// Beat landed at this edge
				beat++;
			end
		end
		st_valid[n] = 1'b0;
		if (st_grant[n]) begin
			report_failure($sformatf("st_grant_%0d still high after the last beat", n));
		end
	endtask

	task automatic load_burst(input int n, input dmem_pkg::address_t base,
			input dmem_pkg::address_t stride, input dmem_pkg::length_t length,
			input int hold_pct);
		dmem_pkg::data_t expect_q [$];
		dmem_pkg::data_t held;
		dmem_pkg::data_t got;
		logic was_held;
		logic ready;
		int beat;
		int k;
		next_cycle();
		ld_req[n] = 1'b1;
		ld_base[n] = base;
		ld_stride[n] = stride;
		ld_length[n] = length;
		while (!ld_grant[n]) next_cycle();
		ld_req[n] = 1'b0;
		for (k = 0; k < length; k++) begin
			expect_q.push_back(model[beat_address(base, stride, k)]);
		end
		beat = 0;
		was_held = 1'b0;
		held = '0;
		while (beat < length) begin
			if (!ld_grant[n]) begin
				report_failure($sformatf("ld_grant_%0d fell after %0d beats", n, beat));
				break;
			end
			got = (n == 1) ? ld_data_1 : ld_data_2;
			if (was_held && !ld_valid[n]) begin
				report_failure($sformatf("ld_valid_%0d dropped while ready was low", n));
			end else if (was_held && got !== held) begin
				report_mismatch($sformatf("ld_data_%0d (held)", n), held, got);
			end
			ready = rand_below(100) >= hold_pct;
			ld_ready[n] = ready;
			if (ld_valid[n] && ready) begin
				if (got !== expect_q[beat]) begin
					report_mismatch($sformatf("ld_data_%0d", n), expect_q[beat], got);
				end
				beat++;
			end
			was_held = ld_valid[n] && !ready;
			held = got;
			next_cycle();
		end
		ld_ready[n] = 1'b0;
		if (ld_grant[n] || ld_valid[n]) begin
			report_failure($sformatf("ld_grant_%0d or ld_valid_%0d high after the last beat",
				n, n));
		end
	endtask

	always @(negedge clock) begin : grant_monitor
		int n;
		if (!reset) begin
			if (st_grant == 2'b11) begin
				report_failure("both store grants high together");
			end
			if (ld_grant == 2'b11) begin
				report_failure("both load grants high together");
			end
			for (n = 1; n <= 2; n++) begin
				if (st_ready[n] !== st_grant[n]) begin
					report_mismatch($sformatf("st_ready_%0d", n), st_grant[n], st_ready[n]);
				end
				if (ld_valid[n] && !ld_grant[n]) begin
					report_failure($sformatf("ld_valid_%0d high without a grant", n));
				end
				if (st_grant[n] && !st_grant_q[n]) st_order.push_back(n);
				if (ld_grant[n] && !ld_grant_q[n]) ld_order.push_back(n);
			end
		end
		st_grant_q = st_grant;
		ld_grant_q = ld_grant;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with bursts still running", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial begin : stimulus
		int i;
		int mark;
		int first;
		dmem_pkg::address_t bases [ROUND_TRIPS];
		dmem_pkg::address_t strides [ROUND_TRIPS];
		dmem_pkg::length_t lengths [ROUND_TRIPS];
		seed = 32'hf0937307;
		mismatches = 0;
		failures = 0;
		st_req = '0;
		st_valid = '0;
		ld_req = '0;
		ld_ready = '0;
		st_grant_q = '0;
		ld_grant_q = '0;
		for (i = 1; i <= 2; i++) begin
			st_base[i] = '0;
			st_stride[i] = '0;
			st_length[i] = '0;
			st_data[i] = '0;
			ld_base[i] = '0;
			ld_stride[i] = '0;
			ld_length[i] = '0;
		end
		for (i = 0; i < ROUND_TRIPS; i++) begin
			bases[i] = dmem_pkg::address_t'(rand_below(dmem_pkg::MEM_DEPTH));
			strides[i] = dmem_pkg::address_t'(rand_below(dmem_pkg::MEM_DEPTH));
			lengths[i] = dmem_pkg::length_t'(1 + rand_below(16));
		end
		bases[0] = dmem_pkg::address_t'(1020);	// Runs past the top address
		strides[0] = dmem_pkg::address_t'(3);
		lengths[0] = dmem_pkg::length_t'(16);

		while (reset !== 1'b0) begin
			@(negedge clock);
			check_idle();
		end
		repeat (2) begin
			@(negedge clock);
			check_idle();
		end

		// Requester 1 goes first after reset
		first = 1;
		mark = st_order.size();
		fork
			store_burst(1, bases[1], strides[1], lengths[1], 20);
			store_burst(2, bases[2], strides[2], lengths[2], 20);
		join
		check_order(1'b0, mark, first);

		for (i = 0; i < FILL_BURSTS; i++) begin
			store_burst(1 + i % 2, dmem_pkg::address_t'(16 * i), dmem_pkg::address_t'(1),
				dmem_pkg::length_t'(16), 10);
		end

		for (i = 0; i < ROUND_TRIPS; i++) begin
			store_burst(1, bases[i], strides[i], lengths[i], 30);
		end
		for (i = 0; i < ROUND_TRIPS; i++) begin
			load_burst(1, bases[i], strides[i], lengths[i], 0);
		end

		// Round trip loads all went to requester 1
		first = 2;
		mark = ld_order.size();
		fork
			load_burst(1, bases[1], strides[1], lengths[1], 0);
			load_burst(2, bases[2], strides[2], lengths[2], 0);
		join
		check_order(1'b1, mark, first);

		for (i = 0; i < PRESSURE_BURSTS; i++) begin
			load_burst(2 - i % 2, bases[i], strides[i], lengths[i], 50);
		end

		// Upper half stores against lower half loads
		fork
			begin : upper_stores
				int j;
				for (j = 0; j < SHARED_BURSTS; j++) begin
					store_burst(2, dmem_pkg::address_t'(512 + bases[j] % 256),
						dmem_pkg::address_t'(strides[j] % 16), lengths[j], 25);
				end
			end
			begin : lower_loads
				int j;
				for (j = 0; j < SHARED_BURSTS; j++) begin
					load_burst(1, dmem_pkg::address_t'(bases[(j + 3) % ROUND_TRIPS] % 256),
						dmem_pkg::address_t'(strides[(j + 3) % ROUND_TRIPS] % 16),
						lengths[(j + 3) % ROUND_TRIPS], 25);
				end
			end
		join

		for (i = 0; i < FILL_BURSTS; i++) begin
			load_burst(1 + i % 2, dmem_pkg::address_t'(16 * i), dmem_pkg::address_t'(1),
				dmem_pkg::length_t'(16), 10);
		end

		$display("Run complete with %0d mismatches and %0d other errors", mismatches,
			failures);
		if (mismatches + failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;	// 40 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* logic/dmem.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem (
	input wire clock,
	input wire reset,
	input wire st_req_1,
	input wire dmem_pkg::address_t st_base_1,
	input wire dmem_pkg::address_t st_stride_1,
	input wire dmem_pkg::length_t st_length_1,
	input wire st_valid_1,
	input wire dmem_pkg::data_t st_data_1,
	output logic st_grant_1,
	output logic st_ready_1,
	input wire st_req_2,
	input wire dmem_pkg::address_t st_base_2,
	input wire dmem_pkg::address_t st_stride_2,
	input wire dmem_pkg::length_t st_length_2,
	input wire st_valid_2,
	input wire dmem_pkg::data_t st_data_2,
	output logic st_grant_2,
	output logic st_ready_2,
	input wire ld_req_1,
	input wire dmem_pkg::address_t ld_base_1,
	input wire dmem_pkg::address_t ld_stride_1,
	input wire dmem_pkg::length_t ld_length_1,
	input wire ld_ready_1,
	output logic ld_grant_1,
	output logic ld_valid_1,
	output dmem_pkg::data_t ld_data_1,
	input wire ld_req_2,
	input wire dmem_pkg::address_t ld_base_2,
	input wire dmem_pkg::address_t ld_stride_2,
	input wire dmem_pkg::length_t ld_length_2,
	input wire ld_ready_2,
	output logic ld_grant_2,
	output logic ld_valid_2,
	output dmem_pkg::data_t ld_data_2
);

	logic write_enable;
	logic read_enable;
	dmem_pkg::address_t write_address;
	dmem_pkg::address_t read_address;
	dmem_pkg::data_t write_data;
	dmem_pkg::data_t read_data;

	store_channel u_store (
		.clock(clock),
		.reset(reset),
		.st_req_1(st_req_1),
		.st_base_1(st_base_1),
		.st_stride_1(st_stride_1),
		.st_length_1(st_length_1),
		.st_valid_1(st_valid_1),
		.st_data_1(st_data_1),
		.st_grant_1(st_grant_1),
		.st_ready_1(st_ready_1),
		.st_req_2(st_req_2),
		.st_base_2(st_base_2),
		.st_stride_2(st_stride_2),
		.st_length_2(st_length_2),
		.st_valid_2(st_valid_2),
		.st_data_2(st_data_2),
		.st_grant_2(st_grant_2),
		.st_ready_2(st_ready_2),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data)
	);

	load_channel u_load (
		.clock(clock),
		.reset(reset),
		.ld_req_1(ld_req_1),
		.ld_base_1(ld_base_1),
		.ld_stride_1(ld_stride_1),
		.ld_length_1(ld_length_1),
		.ld_ready_1(ld_ready_1),
		.ld_grant_1(ld_grant_1),
		.ld_valid_1(ld_valid_1),
		.ld_data_1(ld_data_1),
		.ld_req_2(ld_req_2),
		.ld_base_2(ld_base_2),
		.ld_stride_2(ld_stride_2),
		.ld_length_2(ld_length_2),
		.ld_ready_2(ld_ready_2),
		.ld_grant_2(ld_grant_2),
		.ld_valid_2(ld_valid_2),
		.ld_data_2(ld_data_2),
		.read_enable(read_enable),
		.read_address(read_address),
		.read_data(read_data)
	);

	data_ram u_ram (
		.clock(clock),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.read_enable(read_enable),
		.read_address(read_address),
		.read_data(read_data)
	);

endmodule

`default_nettype wire

/* logic/load_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module load_channel (
	input wire clock,
	input wire reset,
	input wire ld_req_1,
	input wire dmem_pkg::address_t ld_base_1,
	input wire dmem_pkg::address_t ld_stride_1,
	input wire dmem_pkg::length_t ld_length_1,
	input wire ld_ready_1,
	output logic ld_grant_1,
	output logic ld_valid_1,
	output dmem_pkg::data_t ld_data_1,
	input wire ld_req_2,
	input wire dmem_pkg::address_t ld_base_2,
	input wire dmem_pkg::address_t ld_stride_2,
	input wire dmem_pkg::length_t ld_length_2,
	input wire ld_ready_2,
	output logic ld_grant_2,
	output logic ld_valid_2,
	output dmem_pkg::data_t ld_data_2,
	output logic read_enable,
	output dmem_pkg::address_t read_address,
	input wire dmem_pkg::data_t read_data
);

	logic last_one;
	logic pick2;
	logic start;
	logic agu_active;
	logic agu_last;
	logic pending;	// Read issued last cycle, word on read_data
	logic pending_last;
	logic out_valid;
	logic out_last;
	logic out_ready;
	logic drain;
	logic done;
	dmem_pkg::data_t out_data;
	dmem_pkg::address_t base_sel;
	dmem_pkg::address_t stride_sel;
	dmem_pkg::length_t length_sel;

	assign pick2 = ld_req_2 & (~ld_req_1 | last_one);
	assign start = ~(ld_grant_1 | ld_grant_2) & (ld_req_1 | ld_req_2);

	assign base_sel = pick2 ? ld_base_2 : ld_base_1;
	assign stride_sel = pick2 ? ld_stride_2 : ld_stride_1;
	assign length_sel = pick2 ? ld_length_2 : ld_length_1;

	assign out_ready = ld_grant_2 ? ld_ready_2 : ld_ready_1;
	assign drain = out_valid & out_ready;
	assign done = drain & out_last;	// Burst ends when the requester takes the last word

	// One read in flight at most, slot must be free by the time it lands
	assign read_enable = agu_active & ~pending & (~out_valid | drain);

	assign ld_valid_1 = out_valid & ld_grant_1;
	assign ld_valid_2 = out_valid & ld_grant_2;
	assign ld_data_1 = ld_grant_1 ? out_data : '0;
	assign ld_data_2 = ld_grant_2 ? out_data : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			last_one <= 1'b0;
		end else if (ld_grant_1) begin
			last_one <= 1'b1;
		end else if (ld_grant_2) begin
			last_one <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
			pending_last <= 1'b0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			pending <= read_enable;
			pending_last <= agu_last;
			if (pending) begin
				out_valid <= 1'b1;
				out_last <= pending_last;
			end else if (drain) begin
				out_valid <= 1'b0;
				out_last <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pending) begin
			out_data <= read_data;
		end
	end

	burst_arbiter u_arbiter (
		.clock(clock),
		.reset(reset),
		.req1(ld_req_1),
		.req2(ld_req_2),
		.done(done),
		.grant1(ld_grant_1),
		.grant2(ld_grant_2)
	);

	stride_agu u_agu (
		.clock(clock),
		.reset(reset),
		.start(start),
		.step(read_enable),
		.base(base_sel),
		.stride(stride_sel),
		.length(length_sel),
		.address(read_address),
		.active(agu_active),
		.last(agu_last)
	);

	// Held beat keeps its word until taken
	beat_stable: assert property (@(posedge clock) disable iff (reset)
		(out_valid && !out_ready) |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* logic/store_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module store_channel (
	input wire clock,
	input wire reset,
	input wire st_req_1,
	input wire dmem_pkg::address_t st_base_1,
	input wire dmem_pkg::address_t st_stride_1,
	input wire dmem_pkg::length_t st_length_1,
	input wire st_valid_1,
	input wire dmem_pkg::data_t st_data_1,
	output logic st_grant_1,
	output logic st_ready_1,
	input wire st_req_2,
	input wire dmem_pkg::address_t st_base_2,
	input wire dmem_pkg::address_t st_stride_2,
	input wire dmem_pkg::length_t st_length_2,
	input wire st_valid_2,
	input wire dmem_pkg::data_t st_data_2,
	output logic st_grant_2,
	output logic st_ready_2,
	output logic write_enable,
	output dmem_pkg::address_t write_address,
	output dmem_pkg::data_t write_data
);

	logic last_one;	// Requester 1 held the previous grant
	logic pick2;
	logic start;
	logic beat;
	logic agu_last;
	dmem_pkg::address_t base_sel;
	dmem_pkg::address_t stride_sel;
	dmem_pkg::length_t length_sel;

	// Winner of the arbiter's next decision, so the AGU loads as the grant rises
	assign pick2 = st_req_2 & (~st_req_1 | last_one);
	assign start = ~(st_grant_1 | st_grant_2) & (st_req_1 | st_req_2);

	assign base_sel = pick2 ? st_base_2 : st_base_1;
	assign stride_sel = pick2 ? st_stride_2 : st_stride_1;
	assign length_sel = pick2 ? st_length_2 : st_length_1;

	assign st_ready_1 = st_grant_1;
	assign st_ready_2 = st_grant_2;
	assign beat = (st_valid_1 & st_grant_1) | (st_valid_2 & st_grant_2);

	assign write_enable = beat;
	assign write_data = st_grant_2 ? st_data_2 : st_data_1;

	always_ff @(posedge clock) begin
		if (reset) begin
			last_one <= 1'b0;
		end else if (st_grant_1) begin
			last_one <= 1'b1;
		end else if (st_grant_2) begin
			last_one <= 1'b0;
		end
	end

	burst_arbiter u_arbiter (
		.clock(clock),
		.reset(reset),
		.req1(st_req_1),
		.req2(st_req_2),
		.done(agu_last),
		.grant1(st_grant_1),
		.grant2(st_grant_2)
	);

	stride_agu u_agu (
		.clock(clock),
		.reset(reset),
		.start(start),
		.step(beat),
		.base(base_sel),
		.stride(stride_sel),
		.length(length_sel),
		.address(write_address),
		.active(),
		.last(agu_last)
	);

	// Descriptor choice must agree with the arbiter's grant
	winner_match: assert property (@(posedge clock) disable iff (reset)
		start |=> (st_grant_2 == $past(pick2)) && (st_grant_1 == !$past(pick2)));

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
	input wire clock,
	input wire write_enable,
	input wire dmem_pkg::address_t write_address,
	input wire dmem_pkg::data_t write_data,
	input wire read_enable,
	input wire dmem_pkg::address_t read_address,
	output dmem_pkg::data_t read_data
);

	dmem_pkg::data_t mem [dmem_pkg::MEM_DEPTH];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
		end
	end

	// Same-cycle hit on one address returns the old word
	always_ff @(posedge clock) begin
		if (read_enable) begin
			read_data <= mem[read_address];
		end
	end

endmodule

`default_nettype wire

/* logic/stride_agu.sv */
`timescale 1ns/1ps
`default_nettype none

module stride_agu (
	input wire clock,
	input wire reset,
	input wire start,
	input wire step,
	input wire dmem_pkg::address_t base,
	input wire dmem_pkg::address_t stride,
	input wire dmem_pkg::length_t length,
	output dmem_pkg::address_t address,
	output logic active,
	output logic last
);

	dmem_pkg::address_t stride_q;
	dmem_pkg::length_t remaining;	// Beats not yet stepped

	assign last = active & step & (remaining == dmem_pkg::length_t'(1));

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			remaining <= '0;
		end else if (start) begin
			active <= 1'b1;
			remaining <= length;
		end else if (step) begin
			remaining <= remaining - dmem_pkg::length_t'(1);
			if (last) begin
				active <= 1'b0;
			end
		end
	end

	// Wraps modulo the depth by overflow
	always_ff @(posedge clock) begin
		if (start) begin
			address <= base;
			stride_q <= stride;
		end else if (step) begin
			address <= address + stride_q;
		end
	end

	no_empty_burst: assert property (@(posedge clock) disable iff (reset)
		start |-> (length != '0));

	step_when_active: assert property (@(posedge clock) disable iff (reset)
		step |-> active);

endmodule

`default_nettype wire

/* logic/burst_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_arbiter (
	input wire clock,
	input wire reset,
	input wire req1,
	input wire req2,
	input wire done,	// Last beat of the current burst
	output logic grant1,
	output logic grant2
);

	logic busy;
	logic last_two;	// Requester 2 won the previous round

	assign busy = grant1 | grant2;

	always_ff @(posedge clock) begin
		if (reset) begin
			grant1 <= 1'b0;
			grant2 <= 1'b0;
			last_two <= 1'b1;	// Requester 1 goes first
		end else if (busy) begin
			if (done) begin
				grant1 <= 1'b0;
				grant2 <= 1'b0;
			end
		end else if (req1 && (!req2 || last_two)) begin
			grant1 <= 1'b1;
			last_two <= 1'b0;
		end else if (req2) begin
			grant2 <= 1'b1;
			last_two <= 1'b1;
		end
	end

	grant_onehot: assert property (@(posedge clock) disable iff (reset)
		!(grant1 && grant2));

endmodule

`default_nettype wire

/* logic/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

	localparam int ADDR_WIDTH = 10;
	localparam int MEM_DEPTH = 1 << ADDR_WIDTH;	// Address math wraps at this depth
	localparam int DATA_WIDTH = 32;
	localparam int LEN_WIDTH = 5;	// Bursts of 1 to 16 beats

	typedef logic [ADDR_WIDTH-1:0] address_t;	// Word address, also the stride
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [LEN_WIDTH-1:0] length_t;

endpackage

`default_nettype wire
